//--- compile.f
+incdir+.
muldiv_pkg.sv
int_div_ctrl.sv
int_div_dpath.sv
int_mul_iterative.sv
int_muldiv_unit.sv
int_muldiv_asserts.sv
int_muldiv_tb.sv

//--- run.sh
#!/bin/sh
# build and run the multiply/divide unit testbench with Verilator

LOG=sim.log
SIM=int_muldiv_sim

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module int_muldiv_tb -o "$SIM"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -qx "Finished with no errors" "$LOG"
if [ $? -ne 0 ]; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi

echo "simulation passed"
exit 0

//--- int_muldiv_tb.sv
// testbench for the multiply/divide unit
// directed, corner, random and back-pressure runs against a reference model

`timescale 1ns/1ps
`include "muldiv_params.svh"

module int_muldiv_tb;

  import muldiv_pkg::*;

  // about 255 operations at 35 to 45 cycles each
  localparam int MAX_CYCLES = 12000;
  localparam int LATENCY    = `MULDIV_ITERS + 1;

  logic                    clk;
  logic                    reset;
  muldiv_req_t             req;
  logic                    req_val;
  logic                    req_rdy;
  logic [`MULDIV_RLEN-1:0] result;
  logic                    resp_val;
  logic                    resp_rdy = 1'b1;

  // back-pressure on/off and cycles left before resp_rdy flips
  logic bp_en;
  int   bp_left = 0;

  // expected results in request order
  logic [`MULDIV_RLEN-1:0] exp_q[$];
  logic [`MULDIV_RLEN-1:0] want;
  logic [`MULDIV_RLEN-1:0] held_result;
  logic                    acc;
  logic                    xfer;
  logic                    held = 1'b0;
  logic                    in_flight = 1'b0;
  logic                    seen_resp = 1'b0;
  int                      accept_cyc = 0;
  int                      cyc = 0;
  int                      checks = 0;
  int                      errors = 0;

  string                   test_name;
  int                      t_checks;
  int                      t_errors;
  muldiv_op_e              rnd_op;
  logic [`MULDIV_XLEN-1:0] rnd_a;
  logic [`MULDIV_XLEN-1:0] rnd_b;

  int_muldiv_unit uut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .result   (result),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // reference model
  // ------------------------------

  function automatic logic [`MULDIV_RLEN-1:0] ref_muldiv(input muldiv_op_e op,
      input logic [`MULDIV_XLEN-1:0] a, input logic [`MULDIV_XLEN-1:0] b);
    logic signed [`MULDIV_RLEN-1:0] sa;
    logic signed [`MULDIV_RLEN-1:0] sb;
    logic [`MULDIV_XLEN-1:0]        ma;
    logic [`MULDIV_XLEN-1:0]        mb;
    logic [`MULDIV_XLEN-1:0]        q;
    logic [`MULDIV_XLEN-1:0]        r;
    logic                           neg_a;
    logic                           neg_b;
    sa = {{`MULDIV_XLEN{a[`MULDIV_XLEN-1]}}, a};
    sb = {{`MULDIV_XLEN{b[`MULDIV_XLEN-1]}}, b};
    if (op == OP_MUL) begin
      return sa * sb;
    end
    // zero divisor: all-ones quotient, dividend as remainder
    if (b == '0) begin
      return {a, {`MULDIV_XLEN{1'b1}}};
    end
    neg_a = (op == OP_DIV) && a[`MULDIV_XLEN-1];
    neg_b = (op == OP_DIV) && b[`MULDIV_XLEN-1];
    ma = neg_a ? -a : a;
    mb = neg_b ? -b : b;
    q = ma / mb;
    r = ma % mb;
    // truncating divide, remainder follows the dividend
    if (neg_a != neg_b) q = -q;
    if (neg_a) r = -r;
    return {r, q};
  endfunction

  // ------------------------------
  // stimulus helpers
  // ------------------------------

  // hold the request until the DUT takes it
  task automatic send_req(input muldiv_op_e op, input logic [`MULDIV_XLEN-1:0] a,
      input logic [`MULDIV_XLEN-1:0] b);
    req.op  <= op;
    req.a   <= a;
    req.b   <= b;
    req_val <= 1'b1;
    do @(posedge clk); while (!req_rdy);
    req_val <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    t_checks  = checks;
    t_errors  = errors;
  endtask

  // drain outstanding responses, then report this test
  task automatic close_test();
    // one edge first so the compare process has logged the last accept
    @(posedge clk);
    while (in_flight || exp_q.size() != 0) @(posedge clk);
    $display("test %0s: %0d checks, %0d errors", test_name,
             checks - t_checks, errors - t_errors);
  endtask

  // random stretches of resp_rdy high and low
  always @(posedge clk) begin
    if (!bp_en) begin
      resp_rdy <= 1'b1;
    end else if (bp_left == 0) begin
      resp_rdy <= ~resp_rdy;
      bp_left = $urandom % 8;
    end else begin
      bp_left = bp_left - 1;
    end
  end

  // ------------------------------
  // compare and protocol checks
  // ------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      acc  = req_val && req_rdy;
      xfer = resp_val && resp_rdy;
      if (req_rdy && resp_val) begin
        $display("req_rdy and resp_val were high together at cycle %0d", cyc);
        errors++;
      end
      if (acc && in_flight) begin
        $display("a request was accepted at cycle %0d while one was in flight", cyc);
        errors++;
      end
      // stalled response must stay up and unchanged
      if (held && !resp_val) begin
        $display("resp_val dropped at cycle %0d before the response was taken", cyc);
        errors++;
      end else if (held && result !== held_result) begin
        $display("[FAIL] result changed under back-pressure: held 0x%016h, now 0x%016h",
                 held_result, result);
        errors++;
      end
      held        = resp_val && !resp_rdy;
      held_result = result;
      // first cycle of resp_val sets the latency
      if (in_flight && resp_val && !seen_resp) begin
        seen_resp = 1'b1;
        checks++;
        if (cyc - accept_cyc != LATENCY) begin
          $display("response came %0d edges after the accept instead of %0d",
                   cyc - accept_cyc, LATENCY);
          errors++;
        end
      end
      if (xfer) begin
        if (exp_q.size() == 0) begin
          $display("a response arrived at cycle %0d with no request pending", cyc);
          errors++;
        end else begin
          want = exp_q.pop_front();
          checks++;
          if (result !== want) begin
            $display("[FAIL] result expected 0x%016h, got 0x%016h", want, result);
            errors++;
          end
        end
        in_flight = 1'b0;
      end
      if (acc) begin
        exp_q.push_back(ref_muldiv(req.op, req.a, req.b));
        in_flight  = 1'b1;
        seen_resp  = 1'b0;
        accept_cyc = cyc;
      end
    end
  end

  // cycle count and run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the unit stopped returning responses", cyc);
      $display("Finished with errors");
      $finish;
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    void'($urandom(17938));
    reset   = 1'b1;
    req     = '0;
    req_val = 1'b0;
    bp_en   = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    start_test("directed divides");
    send_req(OP_DIVU, 32'd100, 32'd7);
    send_req(OP_DIVU, 32'hFFFF_FFFF, 32'd16);
    send_req(OP_DIVU, 32'd5, 32'd10);
    send_req(OP_DIVU, 32'h8000_0000, 32'd3);
    send_req(OP_DIV, -32'sd100, 32'sd7);
    send_req(OP_DIV, 32'sd100, -32'sd7);
    send_req(OP_DIV, -32'sd100, -32'sd7);
    send_req(OP_DIV, 32'sd7, 32'sd7);
    send_req(OP_DIV, -32'sd1, 32'sd2);
    close_test();

    start_test("corner divides");
    send_req(OP_DIV, 32'd1234, 32'd0);
    send_req(OP_DIV, -32'sd1234, 32'd0);
    send_req(OP_DIVU, 32'hDEAD_BEEF, 32'd0);
    send_req(OP_DIV, 32'd0, 32'd0);
    send_req(OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF);
    send_req(OP_DIVU, 32'h8000_0000, 32'hFFFF_FFFF);
    send_req(OP_DIV, 32'h8000_0000, 32'd1);
    close_test();

    start_test("signed multiplies");
    send_req(OP_MUL, 32'sd3, 32'sd5);
    send_req(OP_MUL, -32'sd3, 32'sd5);
    send_req(OP_MUL, 32'sd3, -32'sd5);
    send_req(OP_MUL, -32'sd3, -32'sd5);
    send_req(OP_MUL, 32'd0, -32'sd1);
    send_req(OP_MUL, 32'h8000_0000, 32'h8000_0000);
    send_req(OP_MUL, 32'h8000_0000, -32'sd1);
    send_req(OP_MUL, 32'h7FFF_FFFF, 32'h7FFF_FFFF);
    send_req(OP_MUL, -32'sd1, -32'sd1);
    close_test();

    start_test("random mix");
    for (int i = 0; i < 200; i++) begin
      rnd_op = muldiv_op_e'($urandom % 3);
      rnd_a  = $urandom;
      // every eighth divisor is small, zero included
      rnd_b  = (i % 8 == 0) ? ($urandom % 16) : $urandom;
      send_req(rnd_op, rnd_a, rnd_b);
    end
    close_test();

    start_test("back-pressure");
    bp_en <= 1'b1;
    for (int i = 0; i < 24; i++) begin
      rnd_op = muldiv_op_e'($urandom % 3);
      rnd_a  = $urandom;
      rnd_b  = $urandom;
      send_req(rnd_op, rnd_a, rnd_b);
    end
    close_test();
    bp_en <= 1'b0;

    start_test("latency");
    send_req(OP_MUL, 32'd77, 32'd91);
    send_req(OP_DIV, -32'sd77, 32'sd9);
    send_req(OP_DIVU, 32'd77, 32'd9);
    close_test();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- int_muldiv_asserts.sv
// handshake assertions for the multiply/divide unit top
// bound onto every int_muldiv_unit instance

`timescale 1ns/1ps
`include "muldiv_params.svh"

module int_muldiv_asserts (
  input logic                    clk,
  input logic                    reset,
  input logic                    req_rdy,
  input logic [`MULDIV_RLEN-1:0] result,
  input logic                    resp_val,
  input logic                    resp_rdy,
  input muldiv_pkg::div_state_e  div_state
);

  import muldiv_pkg::*;

  // ------------------------------
  // handshake
  // ------------------------------

  // one operation at a time, so taking and offering never overlap
  rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else $error("req_rdy and resp_val are high in the same cycle");

  // a stalled response stays up with the same value
  stall_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(result)))
    else $error("response changed or dropped under back-pressure");

  // nothing is offered straight out of reset
  reset_quiet: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high in the cycle after reset");

  // a divide in progress keeps the request side of the top closed
  div_hold_blocks: assert property (@(posedge clk) disable iff (reset)
    (div_state != DIV_IDLE) |-> !req_rdy)
    else $error("req_rdy high while the divider holds an operation");

endmodule

bind int_muldiv_unit int_muldiv_asserts u_asserts (
  .clk       (clk),
  .reset     (reset),
  .req_rdy   (req_rdy),
  .result    (result),
  .resp_val  (resp_val),
  .resp_rdy  (resp_rdy),
  .div_state (u_div_ctrl.state_q)
);

//--- int_muldiv_unit.sv
// multiply/divide unit top
// steers each request to one engine and returns its response in order

`timescale 1ns/1ps
`include "muldiv_params.svh"

module int_muldiv_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  muldiv_pkg::muldiv_req_t req,
  input  logic                    req_val,
  output logic                    req_rdy,
  output logic [`MULDIV_RLEN-1:0] result,
  output logic                    resp_val,
  input  logic                    resp_rdy
);

  import muldiv_pkg::*;

  // one operation in flight, and which engine has it
  logic busy_q;
  logic own_mul_q;

  logic      is_mul;
  logic      accept;
  logic      respond;
  logic      div_req_val;
  logic      div_req_rdy;
  logic      div_resp_val;
  logic      div_resp_rdy;
  logic      mul_req_val;
  logic      mul_req_rdy;
  logic      mul_resp_val;
  logic      mul_resp_rdy;
  div_ctrl_t div_ctrl;

  logic [`MULDIV_RLEN-1:0] div_result;
  logic [`MULDIV_RLEN-1:0] mul_result;

  // ------------------------------
  // request steering
  // ------------------------------

  assign is_mul = (req.op == OP_MUL);

  assign div_req_val = req_val & ~busy_q & ~is_mul;
  assign mul_req_val = req_val & ~busy_q & is_mul;

  // the target engine must also be idle
  assign req_rdy = ~busy_q & (is_mul ? mul_req_rdy : div_req_rdy);
  assign accept  = req_val & req_rdy;

  // ------------------------------
  // response merge
  // ------------------------------

  assign result   = own_mul_q ? mul_result : div_result;
  assign resp_val = own_mul_q ? mul_resp_val : div_resp_val;
  assign respond  = resp_val & resp_rdy;

  // only the owner sees the consumer's ready
  assign div_resp_rdy = resp_rdy & ~own_mul_q;
  assign mul_resp_rdy = resp_rdy & own_mul_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q    <= 1'b0;
      own_mul_q <= 1'b0;
    end else if (accept) begin
      busy_q    <= 1'b1;
      own_mul_q <= is_mul;
    end else if (respond) begin
      busy_q <= 1'b0;
    end
  end

  int_div_ctrl u_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .op       (req.op),
    .ctrl     (div_ctrl),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

  int_div_dpath u_div_dpath (
    .clk    (clk),
    .reset  (reset),
    .a      (req.a),
    .b      (req.b),
    .ctrl   (div_ctrl),
    .result (div_result)
  );

  int_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .a        (req.a),
    .b        (req.b),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .result   (mul_result),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

endmodule

//--- int_mul_iterative.sv
// iterative shift-add multiplier
// signed 32x32 to a 64-bit product, one partial product per cycle

`timescale 1ns/1ps
`include "muldiv_params.svh"

module int_mul_iterative (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`MULDIV_XLEN-1:0] a,
  input  logic [`MULDIV_XLEN-1:0] b,
  input  logic                    req_val,
  output logic                    req_rdy,
  output logic [`MULDIV_RLEN-1:0] result,
  output logic                    resp_val,
  input  logic                    resp_rdy
);

  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_CALC = 2'd1,
    MUL_DONE = 2'd2
  } mul_state_e;

  mul_state_e               state_q;
  logic [`MULDIV_CNT_W-1:0] cnt_q;

  // multiplicand grows left, multiplier drains right
  logic [`MULDIV_RLEN-1:0] mcand_q;
  logic [`MULDIV_XLEN-1:0] mplier_q;
  logic [`MULDIV_RLEN-1:0] prod_q;
  logic                    neg_q;

  logic                    accept;
  logic                    respond;
  logic                    last_step;
  logic [`MULDIV_XLEN-1:0] a_mag;
  logic [`MULDIV_XLEN-1:0] b_mag;

  // ------------------------------
  // handshake
  // ------------------------------

  assign req_rdy  = (state_q == MUL_IDLE);
  assign resp_val = (state_q == MUL_DONE);
  assign accept   = req_val & req_rdy;
  assign respond  = resp_val & resp_rdy;

  assign last_step = (cnt_q == `MULDIV_CNT_W'(`MULDIV_ITERS - 1));

  // magnitudes, min int becomes 2^31 unsigned
  assign a_mag = a[`MULDIV_XLEN-1] ? (~a + 1'b1) : a;
  assign b_mag = b[`MULDIV_XLEN-1] ? (~b + 1'b1) : b;

  // same 1 + 32 edge schedule as the divider
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MUL_IDLE: begin
          if (accept) begin
            state_q <= MUL_CALC;
            cnt_q   <= '0;
          end
        end
        MUL_CALC: begin
          if (last_step) begin
            state_q <= MUL_DONE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        MUL_DONE: begin
          if (respond) begin
            state_q <= MUL_IDLE;
          end
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  // ------------------------------
  // shift-add datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      prod_q   <= '0;
      mcand_q  <= {{(`MULDIV_RLEN - `MULDIV_XLEN){1'b0}}, a_mag};
      mplier_q <= b_mag;
      neg_q    <= a[`MULDIV_XLEN-1] ^ b[`MULDIV_XLEN-1];
    end else if (state_q == MUL_CALC) begin
      // add the multiplicand when the current multiplier bit is set
      if (mplier_q[0]) begin
        prod_q <= prod_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // product sign applied on the way out
  assign result = neg_q ? (~prod_q + 1'b1) : prod_q;

endmodule

//--- int_div_dpath.sv
// restoring divider datapath
// works on magnitudes, then fixes signs and applies the divide-by-zero rule

`timescale 1ns/1ps
`include "muldiv_params.svh"

module int_div_dpath (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`MULDIV_XLEN-1:0] a,
  input  logic [`MULDIV_XLEN-1:0] b,
  input  muldiv_pkg::div_ctrl_t   ctrl,
  output logic [`MULDIV_RLEN-1:0] result
);

  // ------------------------------
  // registers
  // ------------------------------

  // remainder in [64:32], quotient shifts in at [31:0]
  logic [`MULDIV_RLEN:0] rq_q;
  // divisor magnitude lined up under the remainder field
  logic [`MULDIV_RLEN:0] dvs_q;

  // operand signs as seen by a signed divide
  logic a_neg_q;
  logic b_neg_q;
  logic div_zero_q;

  // ------------------------------
  // load-time operand prep
  // ------------------------------

  logic                    a_neg;
  logic                    b_neg;
  logic [`MULDIV_XLEN-1:0] a_mag;
  logic [`MULDIV_XLEN-1:0] b_mag;

  // unsigned divides keep the raw bits
  assign a_neg = ctrl.signed_op & a[`MULDIV_XLEN-1];
  assign b_neg = ctrl.signed_op & b[`MULDIV_XLEN-1];

  // most negative dividend maps to 2^31, which still fits unsigned
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  // ------------------------------
  // one restoring step
  // ------------------------------

  logic [`MULDIV_RLEN:0] rq_shift;
  logic [`MULDIV_RLEN:0] rq_diff;
  logic                  diff_neg;

  assign rq_shift = rq_q << 1;
  // trial subtract of the divisor from the shifted remainder
  assign rq_diff  = rq_shift - dvs_q;
  // borrow out of the top bit means the divisor did not fit
  assign diff_neg = rq_diff[`MULDIV_RLEN];

  // sign and zero flags
  always_ff @(posedge clk) begin
    if (reset) begin
      a_neg_q    <= 1'b0;
      b_neg_q    <= 1'b0;
      div_zero_q <= 1'b0;
    end else if (ctrl.load) begin
      a_neg_q    <= a_neg;
      b_neg_q    <= b_neg;
      div_zero_q <= (b == '0);
    end
  end

  // working registers
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      rq_q  <= {{(`MULDIV_RLEN + 1 - `MULDIV_XLEN){1'b0}}, a_mag};
      dvs_q <= {1'b0, b_mag, {`MULDIV_XLEN{1'b0}}};
    end else if (ctrl.step) begin
      if (diff_neg) begin
        // restore, quotient bit 0
        rq_q <= {rq_shift[`MULDIV_RLEN:1], 1'b0};
      end else begin
        // keep the difference, quotient bit 1
        rq_q <= {rq_diff[`MULDIV_RLEN:1], 1'b1};
      end
    end
  end

  // ------------------------------
  // sign fix-up
  // ------------------------------

  logic [`MULDIV_XLEN-1:0] rem_mag;
  logic [`MULDIV_XLEN-1:0] quot_mag;
  logic                    quot_neg;
  logic                    rem_neg;
  logic [`MULDIV_XLEN-1:0] rem_fix;
  logic [`MULDIV_XLEN-1:0] quot_fix;

  assign rem_mag  = rq_q[`MULDIV_RLEN-1:`MULDIV_XLEN];
  assign quot_mag = rq_q[`MULDIV_XLEN-1:0];

  // quotient sign from the operand signs, remainder follows the dividend
  assign quot_neg = ctrl.signed_op & (a_neg_q ^ b_neg_q);
  assign rem_neg  = ctrl.signed_op & a_neg_q;

  assign quot_fix = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign rem_fix  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

  // divide by zero leaves the dividend as remainder already
  // min / -1 falls out of the magnitude math, 2^31 negated wraps back
  assign result = {rem_fix, div_zero_q ? {`MULDIV_XLEN{1'b1}} : quot_fix};

endmodule

//--- int_div_ctrl.sv
// divider control FSM
// sequences load, 32 restoring steps and the response handshake

`timescale 1ns/1ps
`include "muldiv_params.svh"

module int_div_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_val,
  output logic                   req_rdy,
  input  muldiv_pkg::muldiv_op_e op,
  output muldiv_pkg::div_ctrl_t  ctrl,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  import muldiv_pkg::*;

  div_state_e              state_q;
  logic [`MULDIV_CNT_W-1:0] cnt_q;
  // opcode kind, remembered for the output fix-up
  logic                    signed_q;

  logic accept;
  logic respond;
  logic last_step;

  // ------------------------------
  // handshake
  // ------------------------------

  // only idle takes a request, only done offers a response
  assign req_rdy  = (state_q == DIV_IDLE);
  assign resp_val = (state_q == DIV_DONE);

  assign accept  = req_val & req_rdy;
  assign respond = resp_val & resp_rdy;

  // counter starts at zero, so this is the 32nd step
  assign last_step = (cnt_q == `MULDIV_CNT_W'(`MULDIV_ITERS - 1));

  // ------------------------------
  // state and counter
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= DIV_IDLE;
      cnt_q    <= '0;
      signed_q <= 1'b0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (accept) begin
            state_q  <= DIV_CALC;
            cnt_q    <= '0;
            signed_q <= (op == OP_DIV);
          end
        end
        DIV_CALC: begin
          // one step per edge, leave after the last one
          if (last_step) begin
            state_q <= DIV_DONE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        DIV_DONE: begin
          // back-pressure keeps us here with the result frozen
          if (respond) begin
            state_q <= DIV_IDLE;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  // ------------------------------
  // datapath strobes
  // ------------------------------

  always_comb begin
    ctrl.load = accept;
    ctrl.step = (state_q == DIV_CALC);
    // at load the register is not yet written, so decode the live opcode
    ctrl.signed_op = accept ? (op == OP_DIV) : signed_q;
  end

endmodule

//--- muldiv_pkg.sv
// types shared by the multiply/divide unit
// opcodes, divider states and the structs passed between blocks

`include "muldiv_params.svh"

package muldiv_pkg;

  // ------------------------------
  // operations
  // ------------------------------

  // signed product, signed divide, unsigned divide
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } muldiv_op_e;

  // ------------------------------
  // divider control
  // ------------------------------

  // idle waits for a request, calc iterates, done holds the response
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_CALC = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

  // request payload, held by the requester while req_val is high
  typedef struct packed {
    muldiv_op_e             op;
    logic [`MULDIV_XLEN-1:0] a;
    logic [`MULDIV_XLEN-1:0] b;
  } muldiv_req_t;

  // strobes from the divider FSM to its datapath
  typedef struct packed {
    logic load;
    logic step;
    logic signed_op;
  } div_ctrl_t;

endpackage

//--- muldiv_params.svh
// shared widths and counts for the integer multiply/divide unit
// fixed by the 32-bit ISA, used by the package and every engine

`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// operand width
`define MULDIV_XLEN 32

// full result width, remainder/quotient pair or product
`define MULDIV_RLEN 64

// one iteration per operand bit
`define MULDIV_ITERS 32

// wide enough to hold the iteration count
`define MULDIV_CNT_W 6

`endif
